/* logic/uartPkg.sv */
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// shared definitions for the serial port peripheral
// default byte width, stop ticks, FIFO depth and baud divisor
// oversampling rate common to transmitter and receiver
// status word gathered at the top level
// transmitter and receiver FSM state encodings
////////////////////////////////////////////////////////////////////////////

package uartPkg;

	////////////////////////////////////////////////////////////////////////////
	// defaults, overridden from the top level
	localparam int defaultDataBits = 8;		// one byte per frame
	localparam int defaultSbTick = 16;		// 16 ticks for one stop bit
	localparam int defaultFifoAddrWidth = 4;	// depth of 16 words
	localparam int defaultBaudDivisor = 4;	// clocks per tick

	localparam int ticksPerBit = 16;		// oversampling rate

	////////////////////////////////////////////////////////////////////////////
	// status word seen by the core
	typedef struct packed
	{
		logic txFull;
		logic txEmpty;
		logic rxFull;
		logic rxEmpty;
		logic frameError;	// last frame had a low stop bit
	} uartStatusT;

	// transmitter FSM
	typedef enum logic [1:0]
	{
		txIdle = 2'b00,
		txStartBit = 2'b01,
		txDataBits = 2'b10,
		txStopBit = 2'b11
	} uartTxStateT;

	// receiver FSM
	typedef enum logic [1:0]
	{
		rxIdle = 2'b00,
		rxStartBit = 2'b01,
		rxDataBits = 2'b10,
		rxStopBit = 2'b11
	} uartRxStateT;

endpackage

`default_nettype wire

/* logic/baudTickGen.sv */
`default_nettype none
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// baud tick generator
// free-running divider with a one-cycle tick every baudDivisor clocks
////////////////////////////////////////////////////////////////////////////

module baudTickGen
#(
	parameter int baudDivisor = uartPkg::defaultBaudDivisor
)
(
	input  logic clk,
	input  logic reset,
	output logic sTick
);

	// at least one bit even for a divisor of 1
	localparam int cntWidth = (baudDivisor > 1) ? $clog2(baudDivisor) : 1;

	logic [cntWidth-1:0] cntReg;
	logic rollover;

	assign rollover = (cntReg == cntWidth'(baudDivisor - 1));

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cntReg <= '0;
			sTick <= 1'b0;
		end
		else
		begin
			cntReg <= rollover ? '0 : cntReg + 1'b1;	// wrap at divisor
			sTick <= rollover;			// one tick per period
		end
	end

endmodule

`default_nettype wire

/* logic/uartFifo.sv */
`default_nettype none
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// first-word-fall-through FIFO for the serial port
// register array with extended read and write pointers
// full and empty flags
// push dropped when full and pop ignored when empty
////////////////////////////////////////////////////////////////////////////

module uartFifo
#(
	parameter int width = uartPkg::defaultDataBits,
	parameter int fifoAddrWidth = uartPkg::defaultFifoAddrWidth
)
(
	input  logic             clk,
	input  logic             reset,
	input  logic             push,
	input  logic [width-1:0] pushData,
	input  logic             pop,
	output logic [width-1:0] popData,
	output logic             full,
	output logic             empty
);

	localparam int depth = 2 ** fifoAddrWidth;

	logic [width-1:0] mem [depth];		// storage words

	// one extra bit tells a wrapped writer from an equal one
	logic [fifoAddrWidth:0] wrPtr;
	logic [fifoAddrWidth:0] rdPtr;

	logic doPush;
	logic doPop;

	////////////////////////////////////////////////////////////////////////////
	// flags

	assign empty = (wrPtr == rdPtr);
	assign full = (wrPtr[fifoAddrWidth] != rdPtr[fifoAddrWidth]) &&
		(wrPtr[fifoAddrWidth-1:0] == rdPtr[fifoAddrWidth-1:0]);

	assign doPop = pop & ~empty;			// no underflow
	assign doPush = push & (~full | doPop);	// full slot frees on a pop

	////////////////////////////////////////////////////////////////////////////
	// pointers

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
		end
	end

	// write port
	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr[fifoAddrWidth-1:0]] <= pushData;
	end

	// head shown combinationally
	assign popData = mem[rdPtr[fifoAddrWidth-1:0]];

endmodule

`default_nettype wire

/* logic/uartTransmitter.sv */
`default_nettype none
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// serial transmitter
// four-state FSM paced by the baud tick, 16 ticks per bit
// start bit, data LSB first, stop bit of sbTick ticks
// pops its FIFO as it latches the byte in idle
////////////////////////////////////////////////////////////////////////////

module uartTransmitter
#(
	parameter int dataBits = uartPkg::defaultDataBits,
	parameter int sbTick = uartPkg::defaultSbTick
)
(
	input  logic                clk,
	input  logic                reset,
	input  logic                sTick,
	input  logic                txStart,
	input  logic [dataBits-1:0] din,
	output logic                txDoneTick,
	output logic                tx
);

	import uartPkg::*;

	// tick counter covers a data bit and the stop bit
	localparam int countWidth = $clog2((sbTick > ticksPerBit) ? sbTick : ticksPerBit);
	localparam int bitWidth = (dataBits > 1) ? $clog2(dataBits) : 1;

	uartTxStateT stateReg, stateNext;
	logic [countWidth-1:0] sReg, sNext;	// ticks within a bit
	logic [bitWidth-1:0] nReg, nNext;		// data bits sent
	logic [dataBits-1:0] bReg, bNext;		// shift register
	logic txReg, txNext;				// registered line

	////////////////////////////////////////////////////////////////////////////
	// state registers

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= txIdle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;		// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
		end
	end

	always_ff @(posedge clk)
	begin
		bReg <= bNext;
	end

	////////////////////////////////////////////////////////////////////////////
	// next state

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txDoneTick = 1'b0;

		unique case (stateReg)
			txIdle:
			begin
				if (txStart)
				begin
					txDoneTick = 1'b1;		// pop the FIFO head
					bNext = din;			// current head, same cycle
					sNext = '0;
					stateNext = txStartBit;
				end
			end
			txStartBit:
			begin
				if (sTick)
				begin
					if (sReg == countWidth'(ticksPerBit - 1))
					begin
						sNext = '0;
						nNext = '0;
						stateNext = txDataBits;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			txDataBits:
			begin
				if (sTick)
				begin
					if (sReg == countWidth'(ticksPerBit - 1))
					begin
						sNext = '0;
						bNext = bReg >> 1;		// next bit to the LSB
						if (nReg == bitWidth'(dataBits - 1))
							stateNext = txStopBit;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			txStopBit:
			begin
				if (sTick)
				begin
					if (sReg == countWidth'(sbTick - 1))
						stateNext = txIdle;		// ready next cycle
					else
						sNext = sReg + 1'b1;
				end
			end
		endcase

		// line level follows the next state so tx and state stay aligned
		unique case (stateNext)
			txIdle: txNext = 1'b1;
			txStartBit: txNext = 1'b0;
			txDataBits: txNext = bNext[0];
			txStopBit: txNext = 1'b1;
		endcase
	end

	assign tx = txReg;	// glitch-free from a flop

endmodule

`default_nettype wire

/* logic/uartReceiver.sv */
`default_nettype none
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// serial receiver
// two-flop synchronizer and falling-edge detect on rx
// start bit confirmed at mid-bit, data sampled LSB first
// stop bit check gives either rxDoneTick or frameError
////////////////////////////////////////////////////////////////////////////

module uartReceiver
#(
	parameter int dataBits = uartPkg::defaultDataBits,
	parameter int sbTick = uartPkg::defaultSbTick
)
(
	input  logic                clk,
	input  logic                reset,
	input  logic                sTick,
	input  logic                rx,
	output logic [dataBits-1:0] dout,
	output logic                rxDoneTick,
	output logic                frameError
);

	import uartPkg::*;

	localparam int countWidth = $clog2((sbTick > ticksPerBit) ? sbTick : ticksPerBit);
	localparam int bitWidth = (dataBits > 1) ? $clog2(dataBits) : 1;

	uartRxStateT stateReg, stateNext;
	logic [countWidth-1:0] sReg, sNext;	// ticks since last sample
	logic [bitWidth-1:0] nReg, nNext;		// data bits taken
	logic [dataBits-1:0] bReg, bNext;		// assembled byte
	logic frameErrorReg, frameErrorNext;

	logic rxMeta;			// first sync stage
	logic rxSync;			// safe to use
	logic rxLast;			// for edge detect
	logic fallEdge;

	////////////////////////////////////////////////////////////////////////////
	// input synchronizer

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxLast <= 1'b1;
		end
		else
		begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			rxLast <= rxSync;
		end
	end

	assign fallEdge = rxLast & ~rxSync;

	////////////////////////////////////////////////////////////////////////////
	// state registers

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= rxIdle;
			sReg <= '0;
			nReg <= '0;
			frameErrorReg <= 1'b0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			frameErrorReg <= frameErrorNext;
		end
	end

	always_ff @(posedge clk)
	begin
		bReg <= bNext;
	end

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		frameErrorNext = frameErrorReg;
		rxDoneTick = 1'b0;

		unique case (stateReg)
			rxIdle:
			begin
				if (fallEdge)
				begin
					sNext = '0;
					stateNext = rxStartBit;
				end
			end
			rxStartBit:
			begin
				if (sTick)
				begin
					// middle of the start bit
					if (sReg == countWidth'(ticksPerBit / 2 - 1))
					begin
						sNext = '0;
						nNext = '0;
						// a short glitch has gone high again by now
						stateNext = rxSync ? rxIdle : rxDataBits;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			rxDataBits:
			begin
				if (sTick)
				begin
					if (sReg == countWidth'(ticksPerBit - 1))
					begin
						sNext = '0;
						bNext = {rxSync, bReg[dataBits-1:1]};	// LSB arrives first
						if (nReg == bitWidth'(dataBits - 1))
							stateNext = rxStopBit;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			rxStopBit:
			begin
				if (sTick)
				begin
					if (sReg == countWidth'(sbTick - 1))
					begin
						stateNext = rxIdle;
						if (rxSync)
						begin
							rxDoneTick = 1'b1;	// good byte
							frameErrorNext = 1'b0;
						end
						else
							frameErrorNext = 1'b1;	// stop bit low, byte dropped
					end
					else
						sNext = sReg + 1'b1;
				end
			end
		endcase
	end

	assign dout = bReg;
	assign frameError = frameErrorReg;

endmodule

`default_nettype wire

/* logic/uartPeripheral.sv */
`default_nettype none
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// serial port peripheral top level
// baud tick generator, transmit and receive FIFOs
// transmitter and receiver, status word for the core
////////////////////////////////////////////////////////////////////////////

module uartPeripheral
#(
	parameter int dataBits = uartPkg::defaultDataBits,
	parameter int sbTick = uartPkg::defaultSbTick,
	parameter int fifoAddrWidth = uartPkg::defaultFifoAddrWidth,
	parameter int baudDivisor = uartPkg::defaultBaudDivisor
)
(
	input  logic                clk,
	input  logic                reset,
	input  logic [dataBits-1:0] wrData,
	input  logic                wrStrobe,
	output logic [dataBits-1:0] rdData,
	input  logic                rdStrobe,
	output uartPkg::uartStatusT status,
	output logic                tx,
	input  logic                rx
);

	logic sTick;			// shared baud tick

	// transmit side
	logic [dataBits-1:0] txDin;	// FIFO head to transmitter
	logic txDoneTick;		// pops txFifo
	logic txFull;
	logic txEmpty;

	// receive side
	logic [dataBits-1:0] rxDout;
	logic rxDoneTick;		// pushes rxFifo
	logic rxFull;
	logic rxEmpty;
	logic frameError;

	baudTickGen #(.baudDivisor(baudDivisor)) tickGen
	(
		.clk(clk),
		.reset(reset),
		.sTick(sTick)
	);

	////////////////////////////////////////////////////////////////////////////
	// transmit path

	uartFifo #(.width(dataBits), .fifoAddrWidth(fifoAddrWidth)) txFifo
	(
		.clk(clk),
		.reset(reset),
		.push(wrStrobe),
		.pushData(wrData),
		.pop(txDoneTick),
		.popData(txDin),
		.full(txFull),
		.empty(txEmpty)
	);

	uartTransmitter #(.dataBits(dataBits), .sbTick(sbTick)) transmitter
	(
		.clk(clk),
		.reset(reset),
		.sTick(sTick),
		.txStart(~txEmpty),	// send whenever a byte waits
		.din(txDin),
		.txDoneTick(txDoneTick),
		.tx(tx)
	);

	////////////////////////////////////////////////////////////////////////////
	// receive path

	uartReceiver #(.dataBits(dataBits), .sbTick(sbTick)) receiver
	(
		.clk(clk),
		.reset(reset),
		.sTick(sTick),
		.rx(rx),
		.dout(rxDout),
		.rxDoneTick(rxDoneTick),
		.frameError(frameError)
	);

	uartFifo #(.width(dataBits), .fifoAddrWidth(fifoAddrWidth)) rxFifo
	(
		.clk(clk),
		.reset(reset),
		.push(rxDoneTick),	// dropped when full
		.pushData(rxDout),
		.pop(rdStrobe),
		.popData(rdData),	// head always visible
		.full(rxFull),
		.empty(rxEmpty)
	);

	assign status = '{
		txFull: txFull,
		txEmpty: txEmpty,
		rxFull: rxFull,
		rxEmpty: rxEmpty,
		frameError: frameError
	};

endmodule

`default_nettype wire

/* testbench/uartPeripheralTb.sv */
`default_nettype none
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// testbench for the serial port peripheral
// reset state, frame shape on tx, loopback order
// framing error, receive overflow, glitch rejection on rx
// assertion checks, cycle timeout and a closing summary
////////////////////////////////////////////////////////////////////////////

module uartPeripheralTb;

	import uartPkg::*;

	localparam int dataBits = 8;
	localparam int sbTick = 16;
	localparam int fifoAddrWidth = 4;
	localparam int baudDivisor = 4;
	localparam int fifoDepth = 2 ** fifoAddrWidth;
	localparam int bitClocks = ticksPerBit * baudDivisor;		// 64 clocks
	localparam int frameClocks = (9 * ticksPerBit + sbTick) * baudDivisor;	// 640
	localparam int timeoutCycles = 60 * frameClocks;	// about 1.5x the traffic

	logic clk = 1'b0;
	logic reset;
	logic [dataBits-1:0] wrData;
	logic wrStrobe;
	logic [dataBits-1:0] rdData;
	logic rdStrobe;
	uartStatusT status;
	logic tx;
	logic rx;

	logic loopback;			// rx from the DUT's own tx
	logic rxDrive;			// bit generator level

	logic [dataBits-1:0] expectedQ[$];	// bytes still to be read back
	int errorCount = 0;
	int flagErrors = 0;		// from the concurrent assertion
	int checkCount = 0;
	int testCount = 0;
	int failedTests = 0;
	int testErrorStart = 0;
	int cycleCount = 0;

	assign rx = loopback ? tx : rxDrive;

	uartPeripheral #(
		.dataBits(dataBits),
		.sbTick(sbTick),
		.fifoAddrWidth(fifoAddrWidth),
		.baudDivisor(baudDivisor)
	) DUT
	(
		.clk(clk),
		.reset(reset),
		.wrData(wrData),
		.wrStrobe(wrStrobe),
		.rdData(rdData),
		.rdStrobe(rdStrobe),
		.status(status),
		.tx(tx),
		.rx(rx)
	);

	always #4 clk = ~clk;		// 8 ns period

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= timeoutCycles)
		begin
			$display("timeout: run still going after %0d cycles", timeoutCycles);
			$display("Finished with errors");
			$finish;
		end
	end

	// a FIFO is never full and empty at once
	assert property (@(posedge clk) disable iff (reset)
		!(status.txFull && status.txEmpty) && !(status.rxFull && status.rxEmpty))
	else
	begin
		$display("%0t: a FIFO shows full and empty together", $time);
		flagErrors++;
	end

	////////////////////////////////////////////////////////////////////////////
	// check and report helpers

	task automatic checkValue(input string name, input int actual, input int expected);
		checkCount++;
		assert (actual == expected)
		else
		begin
			$display("[ERROR] %0t %s: expected %0h, got %0h", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic reportFailure(input string what);
		$display("%0t: %s", $time, what);
		errorCount++;
	endtask

	task automatic startTest();
		testErrorStart = errorCount + flagErrors;
		expectedQ.delete();
	endtask

	task automatic endTest(input string name);
		int errs;
		errs = errorCount + flagErrors - testErrorStart;
		testCount++;
		if (errs == 0)
			$display("test %0d %s: passed", testCount, name);
		else
		begin
			failedTests++;
			$display("test %0d %s: failed with %0d errors", testCount, name, errs);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers

	// back-to-back writes with the first keep bytes expected back
	task automatic writeBytes(input int count, input int keep);
		logic [dataBits-1:0] value;
		int i;
		for (i = 0; i < count; i++)
		begin
			@(posedge clk);
			value = dataBits'($urandom());
			wrData <= value;
			wrStrobe <= 1'b1;
			if (i < keep)
				expectedQ.push_back(value);
		end
		@(posedge clk);
		wrStrobe <= 1'b0;
	endtask

	task automatic waitForByte(input int limit, output bit got);
		int i;
		got = 1'b0;
		for (i = 0; i < limit; i++)
		begin
			@(negedge clk);
			if (!status.rxEmpty)
			begin
				got = 1'b1;
				break;
			end
		end
	endtask

	task automatic popByte();
		@(posedge clk);
		rdStrobe <= 1'b1;
		@(posedge clk);
		rdStrobe <= 1'b0;	// exactly one pop
	endtask

	task automatic readBytes(input int count);
		logic [dataBits-1:0] expected;
		bit got;
		int i;
		for (i = 0; i < count; i++)
		begin
			waitForByte(2 * frameClocks, got);
			if (!got)
			begin
				reportFailure($sformatf("byte %0d never reached the receive FIFO", i));
				return;
			end
			expected = expectedQ.pop_front();
			checkValue($sformatf("rdData[%0d]", i), int'(rdData), int'(expected));
			popByte();
		end
	endtask

	// one frame on rx straight from the testbench
	task automatic sendFrame(input logic [dataBits-1:0] data, input logic stopBit);
		logic [dataBits+1:0] bits;
		int i;
		bits = {stopBit, data, 1'b0};	// start bit leaves first
		@(posedge clk);
		for (i = 0; i < dataBits + 2; i++)
		begin
			rxDrive <= bits[i];
			repeat (bitClocks) @(posedge clk);
		end
		rxDrive <= 1'b1;		// back to idle
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence

	initial
	begin
		logic [dataBits-1:0] value;
		bit got;
		bit seenByte;
		bit seenError;
		int expectedBit;
		int i;
		int total;

		reset = 1'b1;
		wrData = '0;
		wrStrobe = 1'b0;
		rdStrobe = 1'b0;
		loopback = 1'b0;
		rxDrive = 1'b1;
		void'($urandom(79514));

		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// reset state and a quiet line until the first write
		startTest();
		@(negedge clk);
		checkValue("status.txEmpty", int'(status.txEmpty), 1);
		checkValue("status.rxEmpty", int'(status.rxEmpty), 1);
		checkValue("status.txFull", int'(status.txFull), 0);
		checkValue("status.rxFull", int'(status.rxFull), 0);
		checkValue("status.frameError", int'(status.frameError), 0);
		for (i = 0; i < 2 * bitClocks; i++)
		begin
			checkValue("tx", int'(tx), 1);
			@(negedge clk);
		end
		endTest("reset state");

		// frame shape sampled near the middle of each bit
		startTest();
		writeBytes(1, 1);
		value = expectedQ.pop_front();
		got = 1'b0;
		for (i = 0; i < 16; i++)
		begin
			@(negedge clk);
			if (!tx)
			begin
				got = 1'b1;
				break;
			end
		end
		if (!got)
			reportFailure("tx never dropped to a start bit after the write");
		else
		begin
			repeat (bitClocks / 2) @(negedge clk);
			for (i = 0; i < dataBits + 2; i++)
			begin
				if (i == 0)
					expectedBit = 0;		// start
				else if (i == dataBits + 1)
					expectedBit = 1;		// stop
				else
					expectedBit = int'((value >> (i - 1)) & 1'b1);	// LSB first
				checkValue($sformatf("tx bit %0d", i), int'(tx), expectedBit);
				repeat (bitClocks) @(negedge clk);
			end
		end
		endTest("frame shape");

		// loopback of one more byte than the FIFO holds
		startTest();
		@(posedge clk);
		loopback <= 1'b1;
		writeBytes(fifoDepth + 1, fifoDepth + 1);
		@(negedge clk);
		checkValue("status.txFull", int'(status.txFull), 1);
		readBytes(fifoDepth + 1);
		endTest("loopback order");

		// low stop bit and then a clean frame
		startTest();
		@(posedge clk);
		loopback <= 1'b0;
		sendFrame(dataBits'($urandom()), 1'b0);
		@(negedge clk);
		checkValue("status.frameError", int'(status.frameError), 1);
		checkValue("status.rxEmpty", int'(status.rxEmpty), 1);
		repeat (bitClocks) @(posedge clk);
		value = dataBits'($urandom());
		expectedQ.push_back(value);
		sendFrame(value, 1'b1);
		readBytes(1);
		@(negedge clk);
		checkValue("status.frameError", int'(status.frameError), 0);
		endTest("framing error");

		// overflow where the last byte has no room
		startTest();
		@(posedge clk);
		loopback <= 1'b1;
		writeBytes(fifoDepth + 1, fifoDepth);
		got = 1'b0;
		for (i = 0; i < 20 * frameClocks; i++)
		begin
			@(negedge clk);
			if (status.txEmpty)
			begin
				got = 1'b1;
				break;
			end
		end
		if (!got)
			reportFailure("transmit FIFO never drained");
		repeat (frameClocks + 2 * bitClocks) @(negedge clk);	// last frame lands
		checkValue("status.rxFull", int'(status.rxFull), 1);
		readBytes(fifoDepth);
		@(negedge clk);
		checkValue("status.rxEmpty", int'(status.rxEmpty), 1);
		endTest("receive overflow");

		// short low pulse that ends well before the mid-bit check
		startTest();
		@(posedge clk);
		loopback <= 1'b0;
		rxDrive <= 1'b0;
		repeat (bitClocks / 4) @(posedge clk);
		rxDrive <= 1'b1;
		seenByte = 1'b0;
		seenError = 1'b0;
		repeat (2 * frameClocks)
		begin
			@(negedge clk);
			if (!status.rxEmpty)
				seenByte = 1'b1;
			if (status.frameError)
				seenError = 1'b1;
		end
		assert (!seenByte)
		else
			reportFailure("a byte was received from a glitch on rx");
		assert (!seenError)
		else
			reportFailure("a glitch on rx raised frameError");
		endTest("glitch rejection");

		total = errorCount + flagErrors;
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testCount, failedTests, checkCount, total);
		if (total == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
logic/uartPkg.sv
logic/baudTickGen.sv
logic/uartFifo.sv
logic/uartTransmitter.sv
logic/uartReceiver.sv
logic/uartPeripheral.sv
testbench/uartPeripheralTb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and pass only on the pass message
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module uartPeripheralTb -f files.f -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -q "Finished with no errors" \
	&& echo "PASS" || { echo "FAIL"; exit 1; }
